// File: compile.f
+incdir+design
design/sieve_pkg.sv
design/command_sequencer.sv
design/mark_generator.sv
design/position_fifo.sv
design/bitmap_updater.sv
design/bitmap_ram.sv
design/sieve_top.sv
verification/sieve_tb.sv

// File: Bender.yml
package:
  name: sieve

sources:
  - include_dirs:
      - design
    files:
      - design/sieve_pkg.sv
      - design/command_sequencer.sv
      - design/mark_generator.sv
      - design/position_fifo.sv
      - design/bitmap_updater.sv
      - design/bitmap_ram.sv
      - design/sieve_top.sv
      - target: test
        files:
          - verification/sieve_tb.sv

// File: verification/sieve_tb.sv
// sieve engine testbench
`default_nettype none
`timescale 1ns/1ps

`include "sieve_defs.svh"

module sieve_tb import sieve_pkg::*; ();

        localparam int word_count     = 1 << `SIEVE_ADDR_W;
        localparam int position_count = 1 << `SIEVE_POS_W;
        localparam int wait_limit     = 40000; // longest mark run plus word changes fits well inside

        logic       clock;
        logic       reset_n;
        logic       start;
        command_t   command;
        bit_pos_t   first_bit;
        bit_pos_t   limit;
        step_t      step;
        word_addr_t read_address;
        logic       command_done;
        word_t      read_data;

        word_t model [word_count];
        int    check_count;
        int    error_count;
        int    protocol_checks;
        int    protocol_errors;
        int    test_checks;
        int    test_errors;

        sieve_top dut (.*);

        always #2 clock = ~clock;

        // bits that one mark run sets inside the given word
        function automatic word_t mark_word_bits(input word_addr_t address, input bit_pos_t first,
                                                 input bit_pos_t last_pos, input step_t stride);
                word_t bits;
                int    position;
                bits = '0;
                for (int index = 0; index < `SIEVE_WORD_W; index++) begin
                        position = int'(address) * `SIEVE_WORD_W + index;
                        if (position >= int'(first) && position <= int'(last_pos) &&
                            (position - int'(first)) % int'(stride) == 0) begin
                                bits[index] = 1'b1;
                        end
                end
                return bits;
        endfunction

        task automatic apply_clear();
                for (int address = 0; address < word_count; address++) begin
                        model[address] = '0;
                end
        endtask

        task automatic apply_mark(input bit_pos_t first, input bit_pos_t last_pos,
                                  input step_t stride);
                int low;
                int high;
                low  = int'(first) >> `SIEVE_BIT_W;
                high = int'(last_pos) >> `SIEVE_BIT_W;
                for (int address = low; address <= high; address++) begin
                        model[address] |= mark_word_bits(word_addr_t'(address), first, last_pos,
                                                         stride);
                end
        endtask

        task automatic finish_run();
                $display("total: %0d checks, %0d errors", check_count + protocol_checks,
                         error_count);
                if (error_count == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        endtask

        // one four-phase exchange that holds start a random while after done
        task automatic run_command(input command_t cmd, input bit_pos_t first,
                                   input bit_pos_t last_pos, input step_t stride,
                                   input word_addr_t address);
                int wait_cycles;
                int hold_cycles;
                @(negedge clock);
                command      = cmd;
                first_bit    = first;
                limit        = last_pos;
                step         = stride;
                read_address = address;
                start        = 1'b1;
                wait_cycles  = 0;
                while (command_done !== 1'b1) begin
                        @(negedge clock);
                        wait_cycles++;
                        if (wait_cycles > wait_limit) begin
                                error_count++;
                                $display("timeout: command_done never rose for %s", cmd.name());
                                finish_run();
                        end
                end
                hold_cycles = $urandom % 6;
                for (int cycle = 0; cycle < hold_cycles; cycle++) begin
                        @(negedge clock);
                        protocol_checks++;
                        if (command_done !== 1'b1) begin
                                protocol_errors++;
                                error_count++;
                                $display("error: command_done is %h with start held, expected 1",
                                         command_done);
                        end
                end
                start = 1'b0;
                @(negedge clock);
                protocol_checks++;
                if (command_done !== 1'b0) begin
                        protocol_errors++;
                        error_count++;
                        $display("error: command_done is %h after start fell, expected 0",
                                 command_done);
                end
        endtask

        task automatic read_and_compare(input word_addr_t address);
                run_command(cmd_read, '0, '0, step_t'(1), address);
                check_count++;
                if (read_data !== model[address]) begin
                        error_count++;
                        $display("error: read_data of word %h is %h, expected %h", address,
                                 read_data, model[address]);
                end
        endtask

        task automatic read_range(input word_addr_t low, input word_addr_t high);
                for (int address = int'(low); address <= int'(high); address++) begin
                        read_and_compare(word_addr_t'(address));
                end
        endtask

        task automatic read_random_words(input int amount);
                repeat (amount) read_and_compare(word_addr_t'($urandom % word_count));
        endtask

        task automatic begin_test();
                test_checks = check_count;
                test_errors = error_count;
        endtask

        task automatic end_test(input string name);
                $display("%s: %0d checks, %0d errors", name, check_count - test_checks,
                         error_count - test_errors);
        endtask

        initial begin
                bit_pos_t first;
                bit_pos_t last_pos;
                step_t    stride;
                int       span;
                int       seed;
                seed = 70;
                void'($urandom(seed));
                clock           = 1'b0;
                reset_n         = 1'b0;
                start           = 1'b0;
                command         = cmd_mark;
                first_bit       = '0;
                limit           = '0;
                step            = step_t'(1);
                read_address    = '0;
                check_count     = 0;
                error_count     = 0;
                protocol_checks = 0;
                protocol_errors = 0;
                repeat (10) @(negedge clock);
                reset_n = 1'b1;

                begin_test();
                check_count += 2;
                if (command_done !== 1'b0) begin
                        error_count++;
                        $display("error: command_done is %h after reset, expected 0", command_done);
                end
                if (read_data !== '0) begin
                        error_count++;
                        $display("error: read_data is %h after reset, expected 0", read_data);
                end
                run_command(cmd_clear, '0, '0, step_t'(1), '0);
                apply_clear();
                read_random_words(20);
                end_test("test 1 reset and clear");

                begin_test();
                first  = bit_pos_t'($urandom % position_count);
                stride = step_t'($urandom % 100 + 1);
                run_command(cmd_mark, first, first, stride, '0);
                apply_mark(first, first, stride);
                read_and_compare(first[`SIEVE_POS_W-1:`SIEVE_BIT_W]);
                read_and_compare(first[`SIEVE_POS_W-1:`SIEVE_BIT_W] + 1'b1);
                end_test("test 2 single bit mark");

                begin_test();
                repeat (6) begin
                        first    = bit_pos_t'($urandom % position_count);
                        span     = int'($urandom % 4000);
                        last_pos = (int'(first) + span > position_count - 1) ?
                                   bit_pos_t'(position_count - 1) : bit_pos_t'(int'(first) + span);
                        stride   = step_t'($urandom % 100 + 1);
                        run_command(cmd_mark, first, last_pos, stride, '0);
                        apply_mark(first, last_pos, stride);
                        read_range(first[`SIEVE_POS_W-1:`SIEVE_BIT_W],
                                   last_pos[`SIEVE_POS_W-1:`SIEVE_BIT_W]);
                        read_random_words(4);
                end
                end_test("test 3 random marks");

                begin_test();
                first = bit_pos_t'($urandom % 10000);
                run_command(cmd_mark, first, first + 14'd1500, step_t'(7), '0);
                apply_mark(first, first + 14'd1500, step_t'(7));
                run_command(cmd_mark, first + 14'd300, first + 14'd2500, step_t'(11), '0);
                apply_mark(first + 14'd300, first + 14'd2500, step_t'(11)); // bits of both runs
                last_pos = first + 14'd2500;
                read_range(first[`SIEVE_POS_W-1:`SIEVE_BIT_W],
                           last_pos[`SIEVE_POS_W-1:`SIEVE_BIT_W]);
                end_test("test 4 overlapping marks");

                begin_test();
                first    = bit_pos_t'(8000 + $urandom % 4000);
                last_pos = first - 14'd1 - bit_pos_t'($urandom % 600);
                run_command(cmd_mark, first, last_pos, step_t'($urandom % 100 + 1), '0);
                read_range(last_pos[`SIEVE_POS_W-1:`SIEVE_BIT_W],
                           first[`SIEVE_POS_W-1:`SIEVE_BIT_W]);
                read_random_words(8);
                end_test("test 5 empty mark");

                $display("test 6 command_done handshake: %0d checks, %0d errors",
                         protocol_checks, protocol_errors);
                finish_run();
        end

endmodule

`default_nettype wire

// File: design/sieve_top.sv
// sieve marking engine
`default_nettype none
`timescale 1ns/1ps

module sieve_top import sieve_pkg::*; (
        input  wire             clock,
        input  wire             reset_n,
        input  wire             start,
        input  wire command_t   command,
        input  wire bit_pos_t   first_bit,
        input  wire bit_pos_t   limit,
        input  wire step_t      step,
        input  wire word_addr_t read_address,
        output wire             command_done,
        output wire word_t      read_data
);

        wire             mark_launch;
        wire             clear_launch;
        wire             read_launch;
        wire             mark_finished;
        wire             clear_finished;
        wire             read_finished;
        wire             run_empty;

        wire             push_valid;
        wire             push_last;
        wire             push_ready;
        wire bit_pos_t   push_position;

        wire             pop_valid;
        wire             pop_last;
        wire             pop_ready;
        wire bit_pos_t   pop_position;

        wire             write_enable;
        wire word_addr_t write_address;
        wire word_t      write_data;
        wire word_addr_t read_address_ram;
        wire word_t      read_data_ram;

        // every port below shares its name with the signal it connects to
        command_sequencer u_command_sequencer (.*);

        mark_generator u_mark_generator (.*);

        position_fifo u_position_fifo (.*);

        bitmap_updater u_bitmap_updater (.*);

        bitmap_ram u_bitmap_ram (.*);

endmodule

`default_nettype wire

// File: design/bitmap_ram.sv
// bitmap memory
`default_nettype none
`timescale 1ns/1ps

`include "sieve_defs.svh"

module bitmap_ram import sieve_pkg::*; (
        input  wire             clock,
        input  wire             write_enable,
        input  wire word_addr_t write_address,
        input  wire word_t      write_data,
        input  wire word_addr_t read_address_ram,
        output word_t           read_data_ram
);

        // contents stay unknown until the first clear sweep
        word_t mem [1 << `SIEVE_ADDR_W];

        always_ff @(posedge clock) begin
                if (write_enable) begin
                        mem[write_address] <= write_data;
                end
                read_data_ram <= mem[read_address_ram]; // old data on a same-address write
        end

endmodule

`default_nettype wire

// File: design/bitmap_updater.sv
// bitmap updater
`default_nettype none
`timescale 1ns/1ps

`include "sieve_defs.svh"

module bitmap_updater import sieve_pkg::*; (
        input  wire             clock,
        input  wire             reset_n,
        input  wire             mark_launch,
        input  wire             clear_launch,
        input  wire             read_launch,
        input  wire word_addr_t read_address,
        input  wire             pop_valid,
        input  wire             pop_last,
        input  wire bit_pos_t   pop_position,
        output logic            pop_ready,
        output logic            write_enable,
        output word_addr_t      write_address,
        output word_t           write_data,
        output word_addr_t      read_address_ram,
        input  wire word_t      read_data_ram,
        output logic            mark_finished,
        output logic            clear_finished,
        output logic            read_finished,
        output word_t           read_data
);

        updater_state_t state;
        word_addr_t     current_address; // held word while marking, sweep address while clearing
        word_t          accumulator;
        logic           held_valid;
        logic           last_held;
        word_addr_t     pop_address;
        word_t          pop_mask;
        logic           same_word;

        assign pop_address = pop_position[`SIEVE_POS_W-1:`SIEVE_BIT_W];
        assign pop_mask    = word_t'(1) << pop_position[`SIEVE_BIT_W-1:0];
        assign same_word   = held_valid && (pop_address == current_address);

        // fetch takes the head entry, merge takes only entries of the held word
        assign pop_ready = (state == upd_fetch) ||
                           ((state == upd_merge) && !last_held && same_word);

        assign write_enable  = (state == upd_clear) || (state == upd_write_back);
        assign write_address = current_address;
        assign write_data    = (state == upd_clear) ? word_t'(0) : (read_data_ram | accumulator);

        assign mark_finished  = (state == upd_write_back) && last_held;
        assign clear_finished = (state == upd_clear) && (&current_address);
        assign read_finished  = (state == upd_capture);

        // the RAM keeps reading the held word so its output is the stored value at write back
        always_comb begin
                case (state)
                upd_fetch: read_address_ram = pop_address;
                upd_read:  read_address_ram = read_address;
                default:   read_address_ram = current_address;
                endcase
        end

        always_ff @(posedge clock) begin
                if (state == upd_fetch) begin
                        accumulator <= pop_mask;
                end else if (pop_valid && pop_ready) begin
                        accumulator <= accumulator | pop_mask;
                end
        end

        always_ff @(posedge clock) begin
                if (reset_n == 1'b0) begin
                        state           <= upd_idle;
                        current_address <= '0;
                        held_valid      <= 1'b0;
                        last_held       <= 1'b0;
                        read_data       <= '0;
                end else if (clear_launch) begin
                        state           <= upd_clear;
                        current_address <= '0;
                end else if (read_launch) begin
                        state <= upd_read;
                end else if (mark_launch) begin
                        // an empty run leaves us here until the next launch
                        state      <= upd_merge;
                        held_valid <= 1'b0;
                        last_held  <= 1'b0;
                end else begin
                        case (state)
                        upd_merge: begin
                                if (last_held) begin
                                        state <= upd_write_back;
                                end else if (pop_valid) begin
                                        if (same_word) begin
                                                if (pop_last) begin
                                                        last_held <= 1'b1;
                                                        state     <= upd_write_back;
                                                end
                                        end else begin
                                                state <= held_valid ? upd_write_back : upd_fetch;
                                        end
                                end
                        end
                        upd_write_back: begin
                                state <= last_held ? upd_idle : upd_fetch;
                        end
                        upd_fetch: begin
                                current_address <= pop_address;
                                held_valid      <= 1'b1;
                                last_held       <= pop_last;
                                state           <= upd_merge;
                        end
                        upd_clear: begin
                                current_address <= current_address + 1'b1;
                                if (&current_address) begin
                                        state <= upd_idle;
                                end
                        end
                        upd_read: begin
                                state <= upd_capture;
                        end
                        upd_capture: begin
                                read_data <= read_data_ram;
                                state     <= upd_idle;
                        end
                        default: begin
                                state <= upd_idle;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: design/position_fifo.sv
// mark position FIFO
`default_nettype none
`timescale 1ns/1ps

`include "sieve_defs.svh"

module position_fifo import sieve_pkg::*; (
        input  wire           clock,
        input  wire           reset_n,
        input  wire           push_valid,
        input  wire           push_last,
        input  wire bit_pos_t push_position,
        output logic          push_ready,
        output logic          pop_valid,
        output logic          pop_last,
        output bit_pos_t      pop_position,
        input  wire           pop_ready
);

        localparam int PTR_W = $clog2(`SIEVE_FIFO_DEPTH);

        bit_pos_t         position_mem [`SIEVE_FIFO_DEPTH];
        logic             last_mem [`SIEVE_FIFO_DEPTH];
        logic [PTR_W-1:0] write_pointer;
        logic [PTR_W-1:0] read_pointer;
        logic [PTR_W:0]   count;
        logic             push_fire;
        logic             pop_fire;

        assign push_ready   = (count != `SIEVE_FIFO_DEPTH);
        assign pop_valid    = (count != 0);
        assign pop_position = position_mem[read_pointer];
        assign pop_last     = last_mem[read_pointer];

        assign push_fire = push_valid && push_ready;
        assign pop_fire  = pop_valid && pop_ready;

        always_ff @(posedge clock) begin
                if (push_fire) begin
                        position_mem[write_pointer] <= push_position;
                        last_mem[write_pointer]     <= push_last;
                end
        end

        always_ff @(posedge clock) begin
                if (reset_n == 1'b0) begin
                        write_pointer <= '0;
                        read_pointer  <= '0;
                        count         <= '0;
                end else begin
                        if (push_fire) begin
                                write_pointer <= write_pointer + 1'b1; // depth is a power of two
                        end
                        if (pop_fire) begin
                                read_pointer <= read_pointer + 1'b1;
                        end
                        case ({push_fire, pop_fire})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: design/mark_generator.sv
// mark position generator
`default_nettype none
`timescale 1ns/1ps

`include "sieve_defs.svh"

module mark_generator import sieve_pkg::*; (
        input  wire           clock,
        input  wire           reset_n,
        input  wire           mark_launch,
        input  wire bit_pos_t first_bit,
        input  wire bit_pos_t limit,
        input  wire step_t    step,
        output logic          push_valid,
        output logic          push_last,
        output bit_pos_t      push_position,
        input  wire           push_ready,
        output logic          run_empty
);

        bit_pos_t              position;
        logic                  active;
        logic [`SIEVE_POS_W:0] next_position; // top bit catches a run off the bitmap end
        logic                  push_fire;

        assign next_position = {1'b0, position} + {1'b0, step};
        assign push_fire     = push_valid && push_ready;

        assign push_valid    = active;
        assign push_position = position;
        assign push_last     = next_position[`SIEVE_POS_W] ||
                               (next_position[`SIEVE_POS_W-1:0] > limit);

        always_ff @(posedge clock) begin
                if (reset_n == 1'b0) begin
                        active    <= 1'b0;
                        run_empty <= 1'b0;
                end else begin
                        run_empty <= mark_launch && (first_bit > limit);
                        if (mark_launch) begin
                                active <= (first_bit <= limit);
                        end else if (push_fire && push_last) begin
                                active <= 1'b0;
                        end
                end
        end

        // outputs stay put while the FIFO holds push_ready low
        always_ff @(posedge clock) begin
                if (mark_launch) begin
                        position <= first_bit;
                end else if (push_fire) begin
                        position <= next_position[`SIEVE_POS_W-1:0];
                end
        end

endmodule

`default_nettype wire

// File: design/command_sequencer.sv
// host command sequencer
`default_nettype none
`timescale 1ns/1ps

module command_sequencer import sieve_pkg::*; (
        input  wire           clock,
        input  wire           reset_n,
        input  wire           start,
        input  wire command_t command,
        output logic          mark_launch,
        output logic          clear_launch,
        output logic          read_launch,
        input  wire           mark_finished,
        input  wire           clear_finished,
        input  wire           read_finished,
        input  wire           run_empty,
        output logic          command_done
);

        sequencer_state_t state;
        logic             finished;
        logic             known_command;

        // an empty mark run finishes in the generator, every other command in the updater
        assign finished = mark_finished | clear_finished | read_finished | run_empty;

        assign known_command = (command == cmd_mark) || (command == cmd_clear) ||
                               (command == cmd_read);

        // command is held stable by the host for the whole transaction
        assign mark_launch  = (state == seq_launch) && (command == cmd_mark);
        assign clear_launch = (state == seq_launch) && (command == cmd_clear);
        assign read_launch  = (state == seq_launch) && (command == cmd_read);

        assign command_done = (state == seq_done);

        always_ff @(posedge clock) begin
                if (reset_n == 1'b0) begin
                        state <= seq_idle;
                end else begin
                        case (state)
                        seq_idle: begin
                                if (start) begin
                                        state <= seq_launch;
                                end
                        end
                        seq_launch: begin
                                // an undefined code has nothing to run and completes at once
                                state <= known_command ? seq_busy : seq_done;
                        end
                        seq_busy: begin
                                if (finished) begin
                                        state <= seq_done;
                                end
                        end
                        seq_done: begin
                                if (!start) begin
                                        state <= seq_idle; // done falls the clock after start
                                end
                        end
                        default: begin
                                state <= seq_idle;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: design/sieve_pkg.sv
// sieve engine types
`default_nettype none

`include "sieve_defs.svh"

package sieve_pkg;

        typedef logic [`SIEVE_WORD_W-1:0] word_t;
        typedef logic [`SIEVE_ADDR_W-1:0] word_addr_t;
        typedef logic [`SIEVE_POS_W-1:0]  bit_pos_t;
        typedef logic [`SIEVE_POS_W-1:0]  step_t;

        typedef enum logic [1:0] {
                cmd_mark  = 2'd0,
                cmd_clear = 2'd1,
                cmd_read  = 2'd2
        } command_t;

        typedef enum logic [1:0] {seq_idle, seq_launch, seq_busy, seq_done} sequencer_state_t;

        typedef enum logic [2:0] {
                upd_idle, upd_merge, upd_write_back, upd_fetch, upd_clear, upd_read, upd_capture
        } updater_state_t;

endpackage

`default_nettype wire

// File: design/sieve_defs.svh
// sieve engine sizes
`ifndef SIEVE_DEFS_SVH
`define SIEVE_DEFS_SVH

`define SIEVE_WORD_W      32
`define SIEVE_ADDR_W      9
`define SIEVE_BIT_W       5

// a bit position is a word address followed by the bit index inside that word
`define SIEVE_POS_W       (`SIEVE_ADDR_W + `SIEVE_BIT_W)

`define SIEVE_FIFO_DEPTH  4

`endif
